//--- Bender.yml
package:
  name: rv_exec

sources:
  - files:
      - source/rv_config_pkg.sv
      - source/rv_isa_pkg.sv
      - source/rv_alu.sv
      - source/rv_operand_stage.sv
      - source/rv_writeback.sv
      - source/rv_exec_top.sv
  - target: simulation
    files:
      - bench/rv_exec_checker.sv
      - bench/rv_exec_tb.sv

//--- bench/rv_exec_checker.sv
`default_nettype none
`timescale 1ns/1ps

module rv_exec_checker
  import rv_config_pkg::*;
(
  input logic                  clk,
  input logic                  arst_n,
  input logic                  result_valid,
  input logic [XLEN-1:0]       result_data,
  input logic                  result_illegal
);

  int fail_count = 0;

  // A result is either legal or illegal, never both
  strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(result_valid && result_illegal))
    else begin
      fail_count++;
      $error("result_valid and result_illegal high together");
    end

  strobes_low_in_reset: assert property (@(posedge clk)
    !arst_n |-> !result_valid && !result_illegal)
    else begin
      fail_count++;
      $error("result strobe high during reset");
    end

  illegal_data_zero: assert property (@(posedge clk) disable iff (!arst_n)
    result_illegal |-> result_data == '0)
    else begin
      fail_count++;
      $error("result_data not zero on an illegal instruction");
    end

endmodule

`default_nettype wire

//--- bench/rv_exec_tb.sv
`default_nettype none
`timescale 1ns/1ps

module rv_exec_tb
  import rv_config_pkg::*;
();

  typedef enum logic [4:0] {
    K_ADD, K_SUB, K_SLL, K_SLT, K_SLTU, K_XOR, K_SRL, K_SRA, K_OR, K_AND,
    K_ADDI, K_SLTI, K_SLTIU, K_XORI, K_ORI, K_ANDI, K_SLLI, K_SRLI, K_SRAI,
    K_BAD_OPC, K_BAD_F7, K_BAD_SHIFT
  } kind_t;

  typedef struct packed {
    kind_t       kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [3:0]  gap;
  } entry_t;

  typedef struct packed {
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    int unsigned           due;
  } expect_t;

  logic                  clk;
  logic                  arst_n;
  logic                  instr_valid;
  logic [31:0]           instr;
  logic                  result_valid;
  logic [REG_ADDR_W-1:0] result_rd;
  logic [XLEN-1:0]       result_data;
  logic                  result_illegal;

  logic [15:0]     lfsr_state = 16'd43922;
  int unsigned     cycle = 0;
  logic [XLEN-1:0] shadow [REG_COUNT];
  entry_t          table_q [$];
  expect_t         expect_q [$];
  expect_t         head;
  int              wait_cycles;

  rv_exec_top u_rv_exec_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .result_valid   (result_valid),
    .result_rd      (result_rd),
    .result_data    (result_data),
    .result_illegal (result_illegal)
  );

  bind rv_exec_top rv_exec_checker u_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .result_illegal (result_illegal)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic [31:0] assemble(input entry_t e);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] word;
    case (e.kind)
      K_ADD, K_SUB, K_ADDI:         f3 = 3'd0;
      K_SLL, K_SLLI, K_BAD_SHIFT:   f3 = 3'd1;
      K_SLT, K_SLTI:                f3 = 3'd2;
      K_SLTU, K_SLTIU:              f3 = 3'd3;
      K_XOR, K_XORI:                f3 = 3'd4;
      K_SRL, K_SRA, K_SRLI, K_SRAI: f3 = 3'd5;
      K_OR, K_ORI:                  f3 = 3'd6;
      default:                      f3 = 3'd7;
    endcase
    f7 = 7'b0000000;
    if (e.kind inside {K_SUB, K_SRA, K_SRAI, K_BAD_SHIFT}) begin
      f7 = 7'b0100000;
    end else if (e.kind == K_BAD_F7) begin
      f7 = 7'b0000001;
    end
    if (e.kind < K_ADDI || e.kind == K_BAD_F7) begin
      word = {f7, e.rs2, e.rs1, f3, e.rd, 7'b0110011};
    end else if (e.kind == K_BAD_OPC) begin
      // LUI opcode, outside this unit
      word = {e.imm, e.rs1, f3, e.rd, 7'b0110111};
    end else if (e.kind >= K_SLLI) begin
      word = {f7, e.imm[4:0], e.rs1, f3, e.rd, 7'b0010011};
    end else begin
      word = {e.imm, e.rs1, f3, e.rd, 7'b0010011};
    end
    return word;
  endfunction

  function automatic logic [31:0] model(input kind_t kind, input logic [31:0] a,
                                        input logic [31:0] b);
    case (kind)
      K_ADD, K_ADDI:   return a + b;
      K_SUB:           return a - b;
      K_SLL, K_SLLI:   return a << b[4:0];
      K_SLT, K_SLTI:   return {31'd0, $signed(a) < $signed(b)};
      K_SLTU, K_SLTIU: return {31'd0, a < b};
      K_XOR, K_XORI:   return a ^ b;
      K_SRL, K_SRLI:   return a >> b[4:0];
      K_SRA, K_SRAI:   return $signed(a) >>> b[4:0];
      K_OR, K_ORI:     return a | b;
      default:         return a & b;
    endcase
  endfunction

  task automatic add_entry(input kind_t kind, input int rd, input int rs1, input int rs2,
                           input logic [31:0] imm, input int gap);
    table_q.push_back('{kind, 5'(rd), 5'(rs1), 5'(rs2), 12'(imm), 4'(gap)});
  endtask

  task automatic apply_entry(input entry_t e);
    logic [31:0] a;
    logic [31:0] b;
    logic        bad;
    logic [31:0] value;
    bad = (e.kind >= K_BAD_OPC);
    a = shadow[e.rs1];
    if (e.kind < K_ADDI) begin
      b = shadow[e.rs2];
    end else if (e.kind >= K_SLLI) begin
      b = {27'd0, e.imm[4:0]};
    end else begin
      b = {{20{e.imm[11]}}, e.imm};
    end
    value = bad ? 32'd0 : model(e.kind, a, b);
    instr_valid = 1'b1;
    instr = assemble(e);
    expect_q.push_back('{bad, e.rd, value, cycle + 2});
    if (!bad && e.rd != 0) begin
      shadow[e.rd] = value;
    end
  endtask

  task automatic build_table();
    add_entry(K_ADD, 3, 1, 2, 0, 2);
    add_entry(K_ADDI, 1, 0, 0, random_bits(12), 0);
    add_entry(K_SLLI, 1, 1, 0, 20, 0);
    add_entry(K_XORI, 1, 1, 0, random_bits(12), 1);
    add_entry(K_ADDI, 2, 0, 0, random_bits(12), 0);
    add_entry(K_SLLI, 2, 2, 0, 17, 0);
    add_entry(K_XORI, 2, 2, 0, random_bits(12), 0);
    // Sign boundary values 0x80000000 and 0x7fffffff
    add_entry(K_ADDI, 4, 0, 0, 1, 0);
    add_entry(K_SLLI, 4, 4, 0, 31, 0);
    add_entry(K_ADDI, 5, 0, 0, -1, 3);
    add_entry(K_SRLI, 5, 5, 0, 1, 0);
    for (int k = 0; k < 10; k++) begin
      add_entry(kind_t'(k), 7 + k, 1, 2, 0, k % 3);
    end
    add_entry(K_SLT, 17, 4, 5, 0, 0);
    add_entry(K_SLTU, 18, 4, 5, 0, 0);
    add_entry(K_SRA, 19, 4, 2, 0, 0);
    add_entry(K_SRA, 20, 4, 5, 0, 1);
    add_entry(K_ADDI, 21, 1, 0, random_bits(12), 0);
    add_entry(K_SLTI, 22, 4, 0, random_bits(12), 0);
    add_entry(K_SLTIU, 23, 5, 0, -1, 0);
    add_entry(K_ANDI, 24, 1, 0, random_bits(12), 2);
    add_entry(K_SRAI, 25, 4, 0, 13, 0);
    // Dependent chain and writes to x0
    add_entry(K_ADD, 7, 7, 1, 0, 0);
    add_entry(K_SUB, 8, 7, 2, 0, 0);
    add_entry(K_ADDI, 0, 8, 0, 5, 0);
    add_entry(K_ADD, 9, 0, 8, 0, 0);
    add_entry(K_BAD_OPC, 10, 1, 0, random_bits(12), 1);
    add_entry(K_BAD_F7, 11, 1, 2, 0, 0);
    add_entry(K_BAD_SHIFT, 12, 1, 0, 3, 0);
    add_entry(K_OR, 27, 10, 11, 0, 0);
    add_entry(K_ADD, 28, 12, 0, 0, 0);
  endtask

  // Results are checked at the falling edge after the output register update
  always @(negedge clk) begin
    if (arst_n && expect_q.size() > 0 && expect_q[0].due == cycle) begin
      head = expect_q.pop_front();
      assert (result_illegal == head.illegal && result_valid == !head.illegal) else begin
        abort_run($sformatf("Fail %0t: strobes valid %b illegal %b, expected illegal %b",
                            $time, result_valid, result_illegal, head.illegal));
      end
      assert (result_data == head.data) else begin
        abort_run($sformatf("Fail %0t: result_data %h, expected %h",
                            $time, result_data, head.data));
      end
      assert (head.illegal || result_rd == head.rd) else begin
        abort_run($sformatf("Fail %0t: result_rd %0d, expected %0d",
                            $time, result_rd, head.rd));
      end
    end else if (arst_n) begin
      assert (!result_valid && !result_illegal) else begin
        abort_run($sformatf("Fail %0t: result strobe without an instruction", $time));
      end
    end
  end

  initial begin
    arst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      shadow[i] = '0;
    end
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int i = 0; i < table_q.size(); i++) begin
      for (int g = 0; g < table_q[i].gap; g++) begin
        @(negedge clk);
        instr_valid = 1'b0;
      end
      @(negedge clk);
      apply_entry(table_q[i]);
    end
    @(negedge clk);
    instr_valid = 1'b0;
    wait_cycles = 0;
    while (expect_q.size() > 0 && wait_cycles < 20) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (expect_q.size() > 0) begin
      abort_run("Expected results did not arrive before the timeout");
    end
    @(negedge clk);
    if (u_rv_exec_top.u_checker.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("A concurrent assertion in the checker failed");
    end
  end

endmodule

`default_nettype wire

//--- rv_exec.f
source/rv_config_pkg.sv
source/rv_isa_pkg.sv
source/rv_alu.sv
source/rv_operand_stage.sv
source/rv_writeback.sv
source/rv_exec_top.sv
bench/rv_exec_checker.sv
bench/rv_exec_tb.sv

//--- source/rv_alu.sv
`default_nettype none
`timescale 1ns/1ps

module rv_alu
  import rv_config_pkg::*;
  import rv_isa_pkg::*;
(
  input  alu_op_t         op,
  input  logic            alternate,
  input  logic [XLEN-1:0] src1,
  input  logic [XLEN-1:0] src2,
  output logic [XLEN-1:0] result
);

  logic                  compare;
  logic                  subtract;
  logic [XLEN-1:0]       src2_alt;
  logic [XLEN-1:0]       sum;
  logic                  carry;
  logic                  overflow;
  logic                  fill;
  logic [4:0][XLEN-1:0]  shl;
  logic [4:0][XLEN-1:0]  shr;

  // slt and sltu both subtract
  assign compare  = (op == ALU_SLT) || (op == ALU_SLTU);
  assign subtract = alternate | compare;
  assign src2_alt = subtract ? ~src2 : src2;

  always_comb begin
    {carry, sum} = {1'b0, src1} + {1'b0, src2_alt} + {{XLEN{1'b0}}, subtract};
  end

  // Operand signs agree but the sum sign differs
  assign overflow = ~(src1[XLEN-1] ^ src2_alt[XLEN-1]) & (src1[XLEN-1] ^ sum[XLEN-1]);

  always_comb begin
    if (src2[4]) begin
      shl[0] = {src1[15:0], 16'd0};
    end else begin
      shl[0] = src1;
    end
    if (src2[3]) begin
      shl[1] = {shl[0][23:0], 8'd0};
    end else begin
      shl[1] = shl[0];
    end
    if (src2[2]) begin
      shl[2] = {shl[1][27:0], 4'd0};
    end else begin
      shl[2] = shl[1];
    end
    if (src2[1]) begin
      shl[3] = {shl[2][29:0], 2'd0};
    end else begin
      shl[3] = shl[2];
    end
    if (src2[0]) begin
      shl[4] = {shl[3][30:0], 1'b0};
    end else begin
      shl[4] = shl[3];
    end
  end

  // Sign fill only for sra
  assign fill = src1[XLEN-1] & alternate;

  always_comb begin
    if (src2[4]) begin
      shr[0] = {{16{fill}}, src1[31:16]};
    end else begin
      shr[0] = src1;
    end
    if (src2[3]) begin
      shr[1] = {{8{fill}}, shr[0][31:8]};
    end else begin
      shr[1] = shr[0];
    end
    if (src2[2]) begin
      shr[2] = {{4{fill}}, shr[1][31:4]};
    end else begin
      shr[2] = shr[1];
    end
    if (src2[1]) begin
      shr[3] = {{2{fill}}, shr[2][31:2]};
    end else begin
      shr[3] = shr[2];
    end
    if (src2[0]) begin
      shr[4] = {fill, shr[3][31:1]};
    end else begin
      shr[4] = shr[3];
    end
  end

  always_comb begin
    case (op)
      ALU_ADD:  result = sum;
      ALU_SLL:  result = shl[4];
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, overflow ^ sum[XLEN-1]};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, ~carry};
      ALU_XOR:  result = src1 ^ src2;
      ALU_SR:   result = shr[4];
      ALU_OR:   result = src1 | src2;
      ALU_AND:  result = src1 & src2;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/rv_config_pkg.sv
`default_nettype none

package rv_config_pkg;

  // Machine word width
  localparam int XLEN = 32;

  // Architectural register file size, x0 included
  localparam int REG_COUNT = 32;

  // Width of rs1, rs2 and rd fields
  localparam int REG_ADDR_W = $clog2(REG_COUNT);

endpackage

`default_nettype wire

//--- source/rv_exec_top.sv
`default_nettype none
`timescale 1ns/1ps

module rv_exec_top
  import rv_config_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  instr_valid,
  input  logic [31:0]           instr,
  output logic                  result_valid,
  output logic [REG_ADDR_W-1:0] result_rd,
  output logic [XLEN-1:0]       result_data,
  output logic                  result_illegal
);

  issue_t          issue;
  commit_t         commit;
  logic [XLEN-1:0] result;

  rv_operand_stage u_operand_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .commit      (commit),
    .issue       (issue)
  );

  rv_alu u_alu (
    .op        (issue.op),
    .alternate (issue.alternate),
    .src1      (issue.src1),
    .src2      (issue.src2),
    .result    (result)
  );

  rv_writeback u_writeback (
    .clk            (clk),
    .arst_n         (arst_n),
    .issue          (issue),
    .result         (result),
    .commit         (commit),
    .result_valid   (result_valid),
    .result_rd      (result_rd),
    .result_data    (result_data),
    .result_illegal (result_illegal)
  );

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  import rv_config_pkg::*;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  // ALU operations follow funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SR   = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_op_t;

  // funct7 values, the alternate one selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // One decoded instruction with its operands
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_t               op;
    logic                  alternate;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
  } issue_t;

  // Register file write, also the forwarding source
  typedef struct packed {
    logic                  write;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } commit_t;

endpackage

`default_nettype wire

//--- source/rv_operand_stage.sv
`default_nettype none
`timescale 1ns/1ps

module rv_operand_stage
  import rv_config_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  commit_t     commit,
  output issue_t      issue
);

  opcode_t               opcode;
  alu_op_t               op;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       shamt;
  logic                  legal;
  logic                  alternate;
  logic                  use_imm;
  logic                  is_shift;
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  issue_t                issue_d;

  // x1..x31, x0 is not stored
  logic [XLEN-1:0]       regs [1:REG_COUNT-1];

  assign opcode = opcode_t'(instr[6:0]);
  assign rd     = instr[11:7];
  assign op     = alu_op_t'(instr[14:12]);
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i    = {{(XLEN-12){instr[31]}}, instr[31:20]};
  assign shamt    = {{(XLEN-5){1'b0}}, instr[24:20]};
  assign is_shift = (op == ALU_SLL) || (op == ALU_SR);

  always_comb begin
    legal     = 1'b0;
    alternate = 1'b0;
    use_imm   = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          legal = 1'b1;
        end else if (funct7 == F7_ALT && (op == ALU_ADD || op == ALU_SR)) begin
          legal     = 1'b1;
          alternate = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (op)
          ALU_SLL: legal = (funct7 == F7_BASE);
          ALU_SR: begin
            legal     = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            alternate = (funct7 == F7_ALT);
          end
          // Upper immediate bits are free for the other ops
          default: legal = 1'b1;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // Register read with bypass of the write happening this cycle
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] value;
    value = '0;
    if (addr != '0) begin
      if (commit.write && commit.rd == addr) begin
        value = commit.data;
      end else begin
        value = regs[addr];
      end
    end
    return value;
  endfunction

  always_comb begin
    rs1_val = read_port(rs1);
    rs2_val = read_port(rs2);
  end

  always_comb begin
    issue_d.valid     = instr_valid;
    issue_d.illegal   = instr_valid & ~legal;
    issue_d.rd        = rd;
    issue_d.op        = op;
    issue_d.alternate = alternate;
    issue_d.src1      = rs1_val;
    if (!use_imm) begin
      issue_d.src2 = rs2_val;
    end else if (is_shift) begin
      issue_d.src2 = shamt;
    end else begin
      issue_d.src2 = imm_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (commit.write) begin
      regs[commit.rd] <= commit.data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue <= '0;
    end else begin
      issue <= issue_d;
    end
  end

endmodule

`default_nettype wire

//--- source/rv_writeback.sv
`default_nettype none
`timescale 1ns/1ps

module rv_writeback
  import rv_config_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  issue_t                issue,
  input  logic [XLEN-1:0]       result,
  output commit_t               commit,
  output logic                  result_valid,
  output logic [REG_ADDR_W-1:0] result_rd,
  output logic [XLEN-1:0]       result_data,
  output logic                  result_illegal
);

  // x0 writes are reported but never reach the register file
  assign commit.write = issue.valid & ~issue.illegal & (issue.rd != '0);
  assign commit.rd    = issue.rd;
  assign commit.data  = result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid   <= 1'b0;
      result_illegal <= 1'b0;
    end else begin
      result_valid   <= issue.valid & ~issue.illegal;
      result_illegal <= issue.valid & issue.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      result_rd   <= issue.rd;
      result_data <= issue.illegal ? '0 : result;
    end
  end

endmodule

`default_nettype wire
